//--- Makefile
# Verilator build and run of the block-statistics testbench
OBJ = obj_dir
LOG = sim.log

all: run

compile:
	verilator --binary --timing -Wno-fatal -f vlog.f --top-module stats_tb \
		-Mdir $(OBJ) -o stats_sim

run: compile
	./$(OBJ)/stats_sim | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then exit 1; fi
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)

.PHONY: all compile run clean

//--- mean_unit.sv
/*
 * Read-only Wishbone master that sums one block and divides by shifting.
 * Pulse start to run it; mean_done flags the truncated mean for one cycle.
 */
`default_nettype none
`include "stats_consts.svh"

module mean_unit (
	input  wire logic                     clk,
	input  wire logic                     rst_n,
	input  wire logic                     start,
	// Wishbone master port
	output logic                          cyc,
	output logic                          stb,
	output logic                          we,
	output logic      [`STATS_ADDR_W-1:0] adr,
	output logic      [`STATS_DATA_W-1:0] dat_w,
	input  wire logic [`STATS_DATA_W-1:0] dat_r,
	input  wire logic                     ack,
	// Result
	output logic      [`STATS_DATA_W-1:0] mean,
	output logic                          mean_done
);
	import stats_pkg::*;

	localparam logic [`STATS_ADDR_W-1:0] LAST_ADR = `STATS_ADDR_W'(`STATS_SAMPLES - 1);

	unit_state_t            state;
	logic [`STATS_ACC_W-1:0] acc;      // Running sum of the block
	logic [`STATS_ACC_W-1:0] acc_next;

	assign acc_next = acc + `STATS_ACC_W'(dat_r); // Sum including the byte on the bus

	// Never writes
	assign we    = 1'b0;
	assign dat_w = '0;

	assign mean_done = (state == ST_FINISH); // One cycle, mean already updated

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			cyc   <= 1'b0;
			stb   <= 1'b0;
			adr   <= '0;
			acc   <= '0;
			mean  <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (start) begin
						cyc   <= 1'b1; // Held for the whole block
						stb   <= 1'b1;
						adr   <= '0;
						acc   <= '0;
						state <= ST_WAIT;
					end
				end
				ST_WAIT: begin
					if (!stb) begin
						stb <= 1'b1; // Gap cycle over, next address already set
					end else if (ack) begin
						acc <= acc_next;
						stb <= 1'b0;
						adr <= adr + 1'b1; // Wraps to zero after the last sample
						if (adr == LAST_ADR) begin
							cyc   <= 1'b0; // Let the bus go
							mean  <= `STATS_DATA_W'(acc_next >> `STATS_ADDR_W);
							state <= ST_FINISH;
						end
					end
				end
				ST_FINISH: state <= ST_IDLE;
				default:   state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- sample_mem.sv
/*
 * Block sample memory with one Wishbone classic slave port.
 * Every access gets a one-cycle registered ack, read data valid with it.
 */
`default_nettype none
`include "stats_consts.svh"

module sample_mem (
	input  wire logic                     clk,
	input  wire logic                     rst_n,
	input  wire logic                     cyc,
	input  wire logic                     stb,
	input  wire logic                     we,
	input  wire logic [`STATS_ADDR_W-1:0] adr,
	input  wire logic [`STATS_DATA_W-1:0] dat_w,
	output logic      [`STATS_DATA_W-1:0] dat_r,
	output logic                          ack
);

	logic [`STATS_DATA_W-1:0] mem [`STATS_SAMPLES]; // One byte per sample
	logic                     req;

	// A held stb right after an ack is not a new request
	assign req = cyc && stb && !ack;

	// Ack is high for exactly one cycle per request
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ack <= 1'b0;
		end else begin
			ack <= req;
		end
	end

	// Storage array and read port
	always_ff @(posedge clk) begin
		if (req) begin
			if (we) begin
				mem[adr] <= dat_w; // Host write
			end
			dat_r <= mem[adr]; // Lands together with ack
		end
	end

endmodule

`default_nettype wire

//--- stats_checker.sv
/*
 * Checker of the statistics engine, sits next to the DUT in the testbench.
 * Mirrors host writes, recomputes mean and variance at each done and compares.
 */
`default_nettype none
`include "stats_consts.svh"

module stats_checker (
	input  wire logic                     clk,
	input  wire logic                     rst_n,
	input  wire logic                     start,
	input  wire logic                     host_cyc,
	input  wire logic                     host_stb,
	input  wire logic                     host_we,
	input  wire logic [`STATS_ADDR_W-1:0] host_adr,
	input  wire logic [`STATS_DATA_W-1:0] host_dat_w,
	input  wire logic [`STATS_DATA_W-1:0] host_dat_r,
	input  wire logic                     host_ack,
	input  wire logic                     busy,
	input  wire logic                     done,
	input  wire logic [`STATS_DATA_W-1:0] mean,
	input  wire logic [`STATS_VAR_W-1:0]  variance,
	input  wire logic                     exp_valid, // Row carries table values
	input  wire logic [`STATS_DATA_W-1:0] exp_mean,
	input  wire logic [`STATS_VAR_W-1:0]  exp_var,
	output int                            errors,
	output int                            checks
);

	logic [`STATS_DATA_W-1:0] mirror [`STATS_SAMPLES]; // Copy of the block as the host wrote it
	logic rst_q    = 1'b0;
	logic done_q   = 1'b0;
	logic run_open = 1'b0; // Accepted start waiting for its done
	int   err_cnt  = 0;
	int   chk_cnt  = 0;

	assign errors = err_cnt;
	assign checks = chk_cnt;

	task automatic compare(input string name, input int got, input int exp);
		chk_cnt = chk_cnt + 1;
		if (got != exp) begin
			err_cnt = err_cnt + 1;
			$display("error: %s is 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic report_failure(input string what);
		err_cnt = err_cnt + 1;
		$display("error: %s", what);
	endtask

	// Truncating mean and population variance, both divided by shifting
	task automatic check_run();
		int i;
		int d;
		int sum;
		int sq_sum;
		int ref_mean;
		int ref_var;
		sum = 0;
		sq_sum = 0;
		for (i = 0; i < `STATS_SAMPLES; i++) sum = sum + int'(mirror[i]);
		ref_mean = sum >> `STATS_ADDR_W;
		for (i = 0; i < `STATS_SAMPLES; i++) begin
			d = int'(mirror[i]) - ref_mean; // Difference from the truncated mean
			sq_sum = sq_sum + d * d;
		end
		ref_var = sq_sum >> `STATS_ADDR_W;
		compare("mean", int'(mean), ref_mean);
		compare("variance", int'(variance), ref_var);
		if (exp_valid) begin
			compare("mean", int'(mean), int'(exp_mean)); // Against the table row
			compare("variance", int'(variance), int'(exp_var));
		end
	endtask

	always @(posedge clk) begin
		rst_q  <= rst_n;
		done_q <= done;
		if (rst_n && !rst_q) begin // First edge out of reset
			compare("busy", int'(busy), 0);
			compare("done", int'(done), 0);
			compare("host_ack", int'(host_ack), 0);
			compare("mean", int'(mean), 0);
			compare("variance", int'(variance), 0);
		end
		if (rst_n) begin
			if (host_cyc && host_stb && host_ack) begin
				if (host_we) mirror[host_adr] = host_dat_w; // Acknowledged write
				else compare("host_dat_r", int'(host_dat_r), int'(mirror[host_adr]));
			end
			if (run_open && !busy) report_failure("busy dropped before done");
			if (done_q && busy) report_failure("busy still high after done");
			if (done && done_q) report_failure("done held for more than one cycle");
			if (done) begin
				if (run_open) check_run();
				else report_failure("done arrived without an accepted start");
				run_open <= 1'b0;
			end
			if (start && !busy) run_open <= 1'b1; // A start during a run opens nothing
		end
	end

endmodule

`default_nettype wire

//--- stats_consts.svh
/*
 * Build-time constants of the block-statistics engine.
 * Included by every RTL file and by the testbench that needs block geometry.
 */
`ifndef STATS_CONSTS_SVH
`define STATS_CONSTS_SVH

// Sample width in bits
`define STATS_DATA_W 8

// Samples per block, must stay a power of two
`define STATS_SAMPLES 64

`define STATS_ADDR_W 6   // log2 of the block size, also the shift for division

`define STATS_VAR_W 16   // Squared difference and variance width, twice the sample width

`define STATS_ACC_W 32   // Sum and sum-of-squares accumulators

`endif

//--- stats_pkg.sv
/*
 * Shared types of the statistics engine.
 * Modules pull these in with a wildcard import inside the module body.
 */
`default_nettype none

package stats_pkg;

	// Sequencer of a reading unit
	typedef enum logic [1:0] {
		ST_IDLE,    // Waiting for its trigger
		ST_WAIT,    // Block read in progress, stb up or in its one-cycle gap
		ST_FINISH   // Last sample taken, result being finalised
	} unit_state_t;

	// Current owner of the sample memory bus
	typedef enum logic [1:0] {
		GNT_NONE,   // Bus free
		GNT_HOST,   // Highest priority
		GNT_VAR,
		GNT_MEAN    // Lowest priority
	} grant_t;

endpackage

`default_nettype wire

//--- stats_tb.sv
/*
 * Testbench top of the block-statistics engine.
 * Loads each table pattern over the host port, runs the engine with host
 * reads and a stray start in between, and leaves the judging to stats_checker.
 */
`default_nettype none
`include "stats_consts.svh"

module stats_tb;

	localparam int N_ROWS  = 6;
	localparam int TIMEOUT = N_ROWS * 10 * `STATS_SAMPLES + 1000; // In cycles

	localparam logic [1:0] PAT_CONST = 2'd0;
	localparam logic [1:0] PAT_RAMP  = 2'd1;
	localparam logic [1:0] PAT_ALT   = 2'd2;
	localparam logic [1:0] PAT_RAND  = 2'd3;

	typedef struct packed {
		logic [1:0]               kind;
		logic                     has_exp;
		logic [`STATS_DATA_W-1:0] exp_mean;
		logic [`STATS_VAR_W-1:0]  exp_var;
	} row_t;

	localparam row_t ROWS [N_ROWS] = '{
		'{PAT_CONST, 1'b1, 8'h5a, 16'd0},     // Flat block with no spread
		'{PAT_RAMP,  1'b1, 8'd31, 16'd341},   // 31.5 and 341.5 truncated
		'{PAT_ALT,   1'b1, 8'd127, 16'd16256},
		'{PAT_RAND,  1'b0, 8'd0, 16'd0},      // Reference only
		'{PAT_RAND,  1'b0, 8'd0, 16'd0},
		'{PAT_RAND,  1'b0, 8'd0, 16'd0}
	};

	logic                     clk, rst_n, start;
	logic                     host_cyc, host_stb, host_we, host_ack;
	logic [`STATS_ADDR_W-1:0] host_adr;
	logic [`STATS_DATA_W-1:0] host_dat_w, host_dat_r, mean, exp_mean;
	logic [`STATS_VAR_W-1:0]  variance, exp_var;
	logic                     busy, done, exp_valid;
	int                       errors, checks;
	int                       cycles    = 0;
	int                       done_seen = 0; // Done pulses so far

	stats_top dut_i (.*);

	stats_checker checker_i (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [`STATS_DATA_W-1:0] sample_value(input logic [1:0] kind,
			input int idx);
		case (kind)
			PAT_CONST: return 8'h5a;
			PAT_RAMP:  return `STATS_DATA_W'(idx);
			PAT_ALT:   return idx[0] ? 8'hff : 8'h00; // Even samples low
			default:   return `STATS_DATA_W'($urandom);
		endcase
	endfunction

	// One classic cycle on the host port with cyc and stb dropped right after ack
	task automatic host_access(input logic wr, input int idx,
			input logic [`STATS_DATA_W-1:0] data);
		@(posedge clk);
		host_cyc   <= 1'b1;
		host_stb   <= 1'b1;
		host_we    <= wr;
		host_adr   <= `STATS_ADDR_W'(idx);
		host_dat_w <= data;
		@(posedge clk);
		while (!host_ack) @(posedge clk); // Arbiter may hold the host off
		host_cyc <= 1'b0;
		host_stb <= 1'b0;
		host_we  <= 1'b0;
	endtask

	task automatic pulse_start();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	initial begin
		void'($urandom(32'ha63cc517));
		rst_n      = 1'b0;
		start      = 1'b0;
		host_cyc   = 1'b0;
		host_stb   = 1'b0;
		host_we    = 1'b0;
		host_adr   = '0;
		host_dat_w = '0;
		exp_valid  = 1'b0;
		exp_mean   = '0;
		exp_var    = '0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		for (int r = 0; r < N_ROWS; r++) begin
			exp_valid <= ROWS[r].has_exp;
			exp_mean  <= ROWS[r].exp_mean;
			exp_var   <= ROWS[r].exp_var;
			for (int i = 0; i < `STATS_SAMPLES; i++)
				host_access(1'b1, i, sample_value(ROWS[r].kind, i));
			pulse_start();
			host_access(1'b0, (r * 7) % `STATS_SAMPLES, 8'h00); // Waits out the mean pass
			pulse_start(); // Engine busy so this one is dropped
			host_access(1'b0, (r * 13 + 5) % `STATS_SAMPLES, 8'h00);
			while (done_seen < r + 1) @(posedge clk);
		end
		repeat (8 * `STATS_SAMPLES) @(posedge clk); // Long enough for a stray run of both passes
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	// Done counter and run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (done) done_seen <= done_seen + 1;
		if (cycles >= TIMEOUT) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT);
			$display("Result: FAILED");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- stats_top.sv
/*
 * Top of the block-statistics engine.
 * Host loads samples over its Wishbone port, pulses start and waits for done.
 */
`default_nettype none
`include "stats_consts.svh"

module stats_top (
	input  wire logic                     clk,
	input  wire logic                     rst_n,
	input  wire logic                     start,
	// Host Wishbone port
	input  wire logic                     host_cyc,
	input  wire logic                     host_stb,
	input  wire logic                     host_we,
	input  wire logic [`STATS_ADDR_W-1:0] host_adr,
	input  wire logic [`STATS_DATA_W-1:0] host_dat_w,
	output logic      [`STATS_DATA_W-1:0] host_dat_r,
	output logic                          host_ack,
	// Status and results
	output logic                          busy,
	output logic                          done,
	output logic      [`STATS_DATA_W-1:0] mean,
	output logic      [`STATS_VAR_W-1:0]  variance
);

	logic                     start_ok;   // Start seen while idle
	logic                     mean_done;
	logic                     var_cyc, var_stb, var_we, var_ack;
	logic [`STATS_ADDR_W-1:0] var_adr;
	logic [`STATS_DATA_W-1:0] var_dat_w, var_dat_r;
	logic                     mean_cyc, mean_stb, mean_we, mean_ack;
	logic [`STATS_ADDR_W-1:0] mean_adr;
	logic [`STATS_DATA_W-1:0] mean_dat_w, mean_dat_r;
	logic                     mem_cyc, mem_stb, mem_we, mem_ack;
	logic [`STATS_ADDR_W-1:0] mem_adr;
	logic [`STATS_DATA_W-1:0] mem_dat_w, mem_dat_r;

	assign start_ok = start && !busy; // A start during a run is dropped

	// Busy spans one full mean plus variance run
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
		end else if (start_ok) begin
			busy <= 1'b1;
		end else if (done) begin
			busy <= 1'b0;
		end
	end

	sample_mem mem_i (
		.clk(clk), .rst_n(rst_n),
		.cyc(mem_cyc), .stb(mem_stb), .we(mem_we), .adr(mem_adr),
		.dat_w(mem_dat_w), .dat_r(mem_dat_r), .ack(mem_ack)
	);

	wb_arbiter arb_i (
		.clk(clk), .rst_n(rst_n),
		.host_cyc(host_cyc), .host_stb(host_stb), .host_we(host_we), .host_adr(host_adr),
		.host_dat_w(host_dat_w), .host_dat_r(host_dat_r), .host_ack(host_ack),
		.var_cyc(var_cyc), .var_stb(var_stb), .var_we(var_we), .var_adr(var_adr),
		.var_dat_w(var_dat_w), .var_dat_r(var_dat_r), .var_ack(var_ack),
		.mean_cyc(mean_cyc), .mean_stb(mean_stb), .mean_we(mean_we), .mean_adr(mean_adr),
		.mean_dat_w(mean_dat_w), .mean_dat_r(mean_dat_r), .mean_ack(mean_ack),
		.mem_cyc(mem_cyc), .mem_stb(mem_stb), .mem_we(mem_we), .mem_adr(mem_adr),
		.mem_dat_w(mem_dat_w), .mem_dat_r(mem_dat_r), .mem_ack(mem_ack)
	);

	mean_unit mean_i (
		.clk(clk), .rst_n(rst_n), .start(start_ok),
		.cyc(mean_cyc), .stb(mean_stb), .we(mean_we), .adr(mean_adr),
		.dat_w(mean_dat_w), .dat_r(mean_dat_r), .ack(mean_ack),
		.mean(mean), .mean_done(mean_done)
	);

	// Second pass starts as soon as the mean is ready
	variance_unit var_i (
		.clk(clk), .rst_n(rst_n), .mean_done(mean_done), .mean(mean),
		.cyc(var_cyc), .stb(var_stb), .we(var_we), .adr(var_adr),
		.dat_w(var_dat_w), .dat_r(var_dat_r), .ack(var_ack),
		.variance(variance), .done(done)
	);

endmodule

`default_nettype wire

//--- variance_unit.sv
/*
 * Read-only Wishbone master that computes the population variance of a block.
 * Starts on mean_done, squares each difference from the latched mean
 * in a two-stage pipeline and pulses done with the shifted sum.
 */
`default_nettype none
`include "stats_consts.svh"

module variance_unit (
	input  wire logic                     clk,
	input  wire logic                     rst_n,
	input  wire logic                     mean_done,
	input  wire logic [`STATS_DATA_W-1:0] mean,
	// Wishbone master port
	output logic                          cyc,
	output logic                          stb,
	output logic                          we,
	output logic      [`STATS_ADDR_W-1:0] adr,
	output logic      [`STATS_DATA_W-1:0] dat_w,
	input  wire logic [`STATS_DATA_W-1:0] dat_r,
	input  wire logic                     ack,
	// Result
	output logic      [`STATS_VAR_W-1:0]  variance,
	output logic                          done
);
	import stats_pkg::*;

	localparam logic [`STATS_ADDR_W-1:0] LAST_ADR = `STATS_ADDR_W'(`STATS_SAMPLES - 1);

	unit_state_t                      state;
	logic        [`STATS_DATA_W-1:0]  mean_q;   // Mean of the current run
	logic signed [`STATS_DATA_W:0]    diff;     // Sample minus mean, one extra sign bit
	logic signed [2*`STATS_DATA_W+1:0] prod;
	logic        [`STATS_VAR_W-1:0]   sq;       // Square stage
	logic                             sq_vld;
	logic        [`STATS_ACC_W-1:0]   acc;      // Sum of squares
	logic        [`STATS_ACC_W-1:0]   acc_next;
	logic                             take;

	assign take = (state == ST_WAIT) && stb && ack; // Sample accepted this cycle

	// Difference formed straight off the bus in the ack cycle
	assign diff     = $signed({1'b0, dat_r}) - $signed({1'b0, mean_q});
	assign prod     = diff * diff;
	assign acc_next = acc + `STATS_ACC_W'(sq);

	assign we    = 1'b0;
	assign dat_w = '0;

	// Square register, only meaningful when sq_vld is set
	always_ff @(posedge clk) begin
		if (take) begin
			sq <= prod[`STATS_VAR_W-1:0]; // At most 255 squared, upper bits always zero
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= ST_IDLE;
			cyc      <= 1'b0;
			stb      <= 1'b0;
			adr      <= '0;
			mean_q   <= '0;
			sq_vld   <= 1'b0;
			acc      <= '0;
			variance <= '0;
			done     <= 1'b0;
		end else begin
			sq_vld <= take;
			done   <= 1'b0;
			if (sq_vld) begin
				acc <= acc_next; // Accumulate while the next read is pending
			end
			case (state)
				ST_IDLE: begin
					if (mean_done) begin
						mean_q <= mean;
						acc    <= '0; // sq_vld is low here
						cyc    <= 1'b1;
						stb    <= 1'b1;
						adr    <= '0;
						state  <= ST_WAIT;
					end
				end
				ST_WAIT: begin
					if (!stb) begin
						stb <= 1'b1;
					end else if (ack) begin
						stb <= 1'b0;
						adr <= adr + 1'b1;
						if (adr == LAST_ADR) begin
							cyc   <= 1'b0;
							state <= ST_FINISH; // Last square still in flight
						end
					end
				end
				ST_FINISH: begin
					// Last square lands in acc_next, divide by the block size
					variance <= `STATS_VAR_W'(acc_next >> `STATS_ADDR_W);
					done     <= 1'b1;
					state    <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
stats_pkg.sv
sample_mem.sv
wb_arbiter.sv
mean_unit.sv
variance_unit.sv
stats_top.sv
stats_checker.sv
stats_tb.sv

//--- wb_arbiter.sv
/*
 * Three-master Wishbone classic arbiter in front of the sample memory.
 * Fixed priority host, variance, mean; the owner keeps the bus while cyc stays high.
 */
`default_nettype none
`include "stats_consts.svh"

module wb_arbiter (
	input  wire logic                     clk,
	input  wire logic                     rst_n,
	// Host master
	input  wire logic                     host_cyc,
	input  wire logic                     host_stb,
	input  wire logic                     host_we,
	input  wire logic [`STATS_ADDR_W-1:0] host_adr,
	input  wire logic [`STATS_DATA_W-1:0] host_dat_w,
	output logic      [`STATS_DATA_W-1:0] host_dat_r,
	output logic                          host_ack,
	// Variance unit master
	input  wire logic                     var_cyc,
	input  wire logic                     var_stb,
	input  wire logic                     var_we,
	input  wire logic [`STATS_ADDR_W-1:0] var_adr,
	input  wire logic [`STATS_DATA_W-1:0] var_dat_w,
	output logic      [`STATS_DATA_W-1:0] var_dat_r,
	output logic                          var_ack,
	// Mean unit master
	input  wire logic                     mean_cyc,
	input  wire logic                     mean_stb,
	input  wire logic                     mean_we,
	input  wire logic [`STATS_ADDR_W-1:0] mean_adr,
	input  wire logic [`STATS_DATA_W-1:0] mean_dat_w,
	output logic      [`STATS_DATA_W-1:0] mean_dat_r,
	output logic                          mean_ack,
	// Memory slave
	output logic                          mem_cyc,
	output logic                          mem_stb,
	output logic                          mem_we,
	output logic      [`STATS_ADDR_W-1:0] mem_adr,
	output logic      [`STATS_DATA_W-1:0] mem_dat_w,
	input  wire logic [`STATS_DATA_W-1:0] mem_dat_r,
	input  wire logic                     mem_ack
);
	import stats_pkg::*;

	grant_t grant;      // Registered owner
	grant_t grant_next;

	// Keep the owner while its cyc is up, otherwise pick by priority
	always_comb begin
		grant_next = grant;
		if (!mem_cyc) begin // mem_cyc mirrors the owner's cyc, low when the bus is free
			if (host_cyc) grant_next = GNT_HOST;
			else if (var_cyc) grant_next = GNT_VAR;
			else if (mean_cyc) grant_next = GNT_MEAN;
			else grant_next = GNT_NONE;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			grant <= GNT_NONE;
		end else begin
			grant <= grant_next;
		end
	end

	// Request path follows the current grant without adding a cycle
	always_comb begin
		mem_cyc   = 1'b0;
		mem_stb   = 1'b0;
		mem_we    = 1'b0;
		mem_adr   = '0;
		mem_dat_w = '0;
		case (grant)
			GNT_HOST: begin
				mem_cyc   = host_cyc;
				mem_stb   = host_stb;
				mem_we    = host_we;
				mem_adr   = host_adr;
				mem_dat_w = host_dat_w;
			end
			GNT_VAR: begin
				mem_cyc   = var_cyc;
				mem_stb   = var_stb;
				mem_we    = var_we;
				mem_adr   = var_adr;
				mem_dat_w = var_dat_w;
			end
			GNT_MEAN: begin
				mem_cyc   = mean_cyc;
				mem_stb   = mean_stb;
				mem_we    = mean_we;
				mem_adr   = mean_adr;
				mem_dat_w = mean_dat_w;
			end
			default: ; // Bus idle
		endcase
	end

	// Read data fans out to everyone, only the owner sees ack
	assign host_dat_r = mem_dat_r;
	assign var_dat_r  = mem_dat_r;
	assign mean_dat_r = mem_dat_r;
	assign host_ack   = mem_ack && (grant == GNT_HOST);
	assign var_ack    = mem_ack && (grant == GNT_VAR);
	assign mean_ack   = mem_ack && (grant == GNT_MEAN);

endmodule

`default_nettype wire
